//--- vlog.f
+incdir+source
source/retire_pkg.sv
source/complete_stage.sv
source/retire_buffer.sv
source/commit_stage.sv
source/retire_unit.sv
bench/retire_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module retire_tb -f vlog.f -o retire_sim \
    || { echo "verilator build error"; exit 1; }
./obj_dir/retire_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line in log"; exit 1; }
exit 0

//--- bench/retire_tb.sv
`include "retire_settings.svh"

module retire_tb
    import retire_pkg::*;
();

    // packets issued over all tests set the watchdog length
    localparam int ISSUED_PKTS     = 56;
    localparam int WATCHDOG_CYCLES = ISSUED_PKTS * 200 + 1000;

    logic             clock;
    logic             rst_n;
    logic             flush;
    complete_packet_t co_packet;
    commit_t          commit;
    store_req_t       store_req;
    logic [31:0]      completed_insts;
    logic             halted;

    // model state
    int               model_head;
    commit_t          exp_commit_q [$];
    store_req_t       exp_store_q [$];
    complete_packet_t batch [`ROB_SZ];
    int               order [`ROB_SZ];
    logic [31:0]      lfsr_state;
    logic [31:0]      stores_seen;

    // bookkeeping
    int               errors;
    int               checks;
    int               tests;
    int               test_start;

    retire_unit retire_unit_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (flush),
        .co_packet       (co_packet),
        .commit          (commit),
        .store_req       (store_req),
        .completed_insts (completed_insts),
        .halted          (halted)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // expected commit and store for one report
    function automatic void expected_result(input complete_packet_t p, output commit_t c,
                                            output store_req_t s);
        c.valid = 1'b1;
        if (p.illegal) begin
            c.error_status = ILLEGAL_INST;
        end else if (p.halt) begin
            c.error_status = HALTED_ON_WFI;
        end else begin
            c.error_status = NO_ERROR;
        end
        c.wr_en   = p.regfile_en;
        c.wr_idx  = p.inst.r.rd;
        c.wr_data = p.regfile_data;
        c.npc     = p.npc;
        s = '0;
        if (p.function_type == STORE) begin
            s.valid = 1'b1;
            // sb, sh, sw
            case (p.inst.s.funct3)
                3'b000: begin
                    s.size = BYTE;
                end
                3'b001: begin
                    s.size = HALF;
                end
                default: begin
                    s.size = WORD;
                end
            endcase
            s.addr = p.result;
            s.data = p.opb_value;
        end
    endfunction

    task automatic check_commit(input commit_t got, input commit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL commit got %h expected %h", got, exp);
        end
    endtask

    // payload only matters when a store is expected
    task automatic check_store(input store_req_t got, input store_req_t exp);
        checks++;
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            errors++;
            $display("FAIL store_req got %h expected %h", got, exp);
        end
    endtask

    task automatic check_count(input logic [31:0] got, input logic [31:0] exp,
                               input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // drive point just after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic settle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #10;
        rst_n      = 1'b1;
        model_head = 0;
        exp_commit_q.delete();
        exp_store_q.delete();
    endtask

    task automatic make_packet(input int slot, input funit_e ft, input exception_e fault,
                               output complete_packet_t p);
        logic [31:0] r;
        p           = '0;
        p.valid     = 1'b1;
        p.rob_index = slot[`ROB_IDX_W-1:0];
        take_bits(32, r);
        p.inst = r;
        case (ft)
            STORE: begin
                p.inst.s.opcode = 7'b0100011;
                take_bits(2, r);
                // funct3 kept to the three legal store widths
                p.inst.s.funct3 = (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]};
            end
            LOAD: begin
                p.inst.r.opcode = 7'b0000011;
            end
            BRANCH: begin
                p.inst.r.opcode = 7'b1100011;
            end
            default: begin
                p.inst.r.opcode = 7'b0110011;
            end
        endcase
        p.function_type = ft;
        p.illegal       = (fault == ILLEGAL_INST);
        p.halt          = (fault == HALTED_ON_WFI);
        take_bits(30, r);
        p.pc         = {r[29:0], 2'b00};
        p.npc        = p.pc + 32'd4;
        p.regfile_en = (ft == ALU) || (ft == LOAD);
        take_bits(32, r);
        p.regfile_data = r;
        take_bits(32, r);
        p.result = r;
        take_bits(32, r);
        p.opb_value = r;
    endtask

    // mode 0 picks random unit types
    // mode 1 cycles through alu load store
    // first expect_n entries get queued in slot order from the head
    task automatic build_batch(input int n, input int start, input int mode, input int fault_at,
                               input exception_e fault, input int expect_n);
        funit_e      ft;
        exception_e  fe;
        logic [31:0] r;
        commit_t     c;
        store_req_t  s;
        for (int i = 0; i < n; i++) begin
            if (mode == 0) begin
                take_bits(2, r);
                ft = funit_e'(r[1:0]);
            end else begin
                case (i % 3)
                    0: begin
                        ft = ALU;
                    end
                    1: begin
                        ft = LOAD;
                    end
                    default: begin
                        ft = STORE;
                    end
                endcase
            end
            fe = (i == fault_at) ? fault : NO_ERROR;
            make_packet((start + i) % `ROB_SZ, ft, fe, batch[i]);
        end
        for (int i = 0; i < expect_n; i++) begin
            expected_result(batch[i], c, s);
            exp_commit_q.push_back(c);
            exp_store_q.push_back(s);
        end
        model_head = (model_head + expect_n) % `ROB_SZ;
    endtask

    // fisher-yates shuffle then one report per cycle
    task automatic send_batch(input int n);
        logic [31:0] r;
        int          j;
        int          t;
        for (int i = 0; i < n; i++) begin
            order[i] = i;
        end
        for (int i = n - 1; i > 0; i--) begin
            take_bits(4, r);
            j        = int'(r[3:0]) % (i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < n; i++) begin
            co_packet = batch[order[i]];
            next_cycle();
        end
        co_packet = '0;
    endtask

    // two quiet cycles expose any extra commit
    task automatic wait_drained();
        while (exp_commit_q.size() != 0) begin
            next_cycle();
        end
        settle(2);
    endtask

    task automatic start_test();
        test_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_start);
        end
    endtask

    // commit outputs are stable by the falling edge
    always @(negedge clock) begin
        if (rst_n && commit.valid) begin
            if (store_req.valid) begin
                stores_seen = stores_seen + 32'd1;
            end
            if (exp_commit_q.size() == 0) begin
                errors++;
                $display("commit seen while no instruction was due to retire");
            end else begin
                check_commit(commit, exp_commit_q.pop_front());
                check_store(store_req, exp_store_q.pop_front());
            end
        end else if (rst_n && store_req.valid) begin
            errors++;
            $display("store request raised without a commit");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] base;
        logic [31:0] store_base;
        int          park_start;
        lfsr_state  = 32'd97691;
        stores_seen = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        co_packet   = '0;
        apply_reset();

        // shuffled full window retires in slot order
        start_test();
        base = completed_insts;
        build_batch(16, model_head, 0, -1, NO_ERROR, 16);
        send_batch(16);
        wait_drained();
        check_count(completed_insts, base + 32'd16, "completed_insts");
        finish_test("out of order batch");

        // head report into an empty buffer
        start_test();
        base = completed_insts;
        build_batch(1, model_head, 0, -1, NO_ERROR, 1);
        co_packet = batch[0];
        next_cycle();
        co_packet = '0;
        check_level(commit.valid, 1'b0, "commit.valid");
        next_cycle();
        check_level(commit.valid, 1'b1, "commit.valid");
        wait_drained();
        check_count(completed_insts, base + 32'd1, "completed_insts");
        finish_test("head forwarding");

        // three each of alu load and store
        start_test();
        base       = completed_insts;
        store_base = stores_seen;
        build_batch(9, model_head, 1, -1, NO_ERROR, 9);
        send_batch(9);
        wait_drained();
        check_count(completed_insts, base + 32'd9, "completed_insts");
        check_count(stores_seen - store_base, 32'd3, "store_req count");
        finish_test("store requests");

        // parked behind a missing head then flushed
        start_test();
        base       = completed_insts;
        park_start = (model_head + 1) % `ROB_SZ;
        build_batch(5, park_start, 0, -1, NO_ERROR, 0);
        send_batch(5);
        settle(4);
        check_count(completed_insts, base, "completed_insts");
        flush = 1'b1;
        next_cycle();
        flush      = 1'b0;
        model_head = 0;
        // refill every slot below the flushed ones
        // a stale parked entry would retire once the head reaches it
        build_batch(park_start, 0, 0, -1, NO_ERROR, park_start);
        send_batch(park_start);
        wait_drained();
        check_count(completed_insts, base + park_start, "completed_insts");
        finish_test("flush");

        // illegal at the fourth slot leaves the rest parked
        start_test();
        base = completed_insts;
        build_batch(8, model_head, 0, 3, ILLEGAL_INST, 4);
        send_batch(8);
        wait_drained();
        settle(4);
        check_level(halted, 1'b1, "halted");
        check_count(completed_insts, base + 32'd4, "completed_insts");
        finish_test("halt on illegal");

        // fresh start then wfi at the third slot
        start_test();
        apply_reset();
        check_level(halted, 1'b0, "halted");
        check_count(completed_insts, 32'd0, "completed_insts");
        build_batch(6, 0, 0, 2, HALTED_ON_WFI, 3);
        send_batch(6);
        wait_drained();
        settle(4);
        check_level(halted, 1'b1, "halted");
        check_count(completed_insts, 32'd3, "completed_insts");
        finish_test("halt on wfi");

        if (exp_commit_q.size() != 0) begin
            errors++;
            $display("instructions still waiting to retire at end of run");
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/retire_unit.sv
`include "retire_settings.svh"

module retire_unit
    import retire_pkg::*;
(
    input  logic             clock,
    input  logic             rst_n,
    input  logic             flush,
    input  complete_packet_t co_packet,
    output commit_t          commit,
    output store_req_t       store_req,
    output logic [31:0]      completed_insts,
    output logic             halted
);

    // completion register to buffer
    retire_entry_t         in_entry;
    logic [`ROB_IDX_W-1:0] in_index;

    // buffer to commit register
    retire_entry_t         out_entry;

    // report in, entry out one cycle later
    complete_stage complete_stage_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush),
        .co_packet (co_packet),
        .in_entry  (in_entry),
        .in_index  (in_index)
    );

    // reorder slots, head bypass, in-order release
    retire_buffer retire_buffer_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush),
        .halted    (halted),
        .in_entry  (in_entry),
        .in_index  (in_index),
        .out_entry (out_entry)
    );

    // commit and store ports, halt level fed back to the buffer
    commit_stage commit_stage_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .out_entry       (out_entry),
        .commit          (commit),
        .store_req       (store_req),
        .completed_insts (completed_insts),
        .halted          (halted)
    );

endmodule

//--- source/commit_stage.sv
module commit_stage
    import retire_pkg::*;
(
    input  logic          clock,
    input  logic          rst_n,
    input  retire_entry_t out_entry,
    output commit_t       commit,
    output store_req_t    store_req,
    output logic [31:0]   completed_insts,
    output logic          halted
);

    // control flops
    logic       commit_valid_q;
    logic       store_valid_q;

    // payload flops
    commit_t    commit_q;
    store_req_t store_q;

    // decode of the leaving entry
    logic       is_store;
    logic       is_fault;

    assign is_store = out_entry.valid && (out_entry.function_type == STORE);
    assign is_fault = out_entry.valid && (out_entry.error_status != NO_ERROR);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid_q  <= 1'b0;
            store_valid_q   <= 1'b0;
            completed_insts <= '0;
            halted          <= 1'b0;
        end else begin
            commit_valid_q <= out_entry.valid;
            store_valid_q  <= is_store;
            if (out_entry.valid) begin
                completed_insts <= completed_insts + 32'd1;
            end
            // sticky until reset
            // faulting instruction itself still retires and counts
            if (is_fault) begin
                halted <= 1'b1;
            end
        end
    end

    // payload holds between retirements
    always_ff @(posedge clock) begin
        if (out_entry.valid) begin
            commit_q <= '{
                valid:        out_entry.valid,
                error_status: out_entry.error_status,
                wr_en:        out_entry.regfile_en,
                wr_idx:       out_entry.regfile_idx,
                wr_data:      out_entry.regfile_data,
                npc:          out_entry.npc
            };
        end
        // address from result, data from operand b
        if (is_store) begin
            store_q <= '{
                valid: is_store,
                size:  out_entry.mem_size,
                addr:  out_entry.result,
                data:  out_entry.opb_value
            };
        end
    end

    // valid bits come from the reset flops
    always_comb begin
        commit          = commit_q;
        commit.valid    = commit_valid_q;
        store_req       = store_q;
        store_req.valid = store_valid_q;
    end

    // buffer must go quiet once halted reaches it
    a_quiet_when_halted: assert property (
        @(posedge clock) disable iff (!rst_n)
        halted |-> !out_entry.valid
    ) else $error("commit_stage: entry retired after halt");

endmodule

//--- source/retire_buffer.sv
`include "retire_settings.svh"

module retire_buffer
    import retire_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  halted,
    input  retire_entry_t         in_entry,
    input  logic [`ROB_IDX_W-1:0] in_index,
    output retire_entry_t         out_entry
);

    // slot payload, valid bits kept in a separate vector
    retire_entry_t         slot_q [`ROB_SZ];
    logic [`ROB_SZ-1:0]    slot_valid;

    // oldest unretired slot
    logic [`ROB_IDX_W-1:0] head;

    logic                  do_forward;
    logic                  do_park;
    logic                  do_retire;

    // arriving entry is the head itself, skip the slot
    // no bypass while halted or while the buffer is being emptied
    assign do_forward = in_entry.valid && (in_index == head) && !halted && !flush;

    // everything else that arrives waits in its slot
    // this includes the head slot while halted
    assign do_park = in_entry.valid && !do_forward;

    always_comb begin
        if (do_forward) begin
            out_entry = in_entry;
        end else begin
            out_entry       = slot_q[head];
            out_entry.valid = slot_valid[head];
        end
        // nothing leaves while halted
        // nothing leaves in the flush cycle either, it belongs to the flushed window
        if (halted || flush) begin
            out_entry.valid = 1'b0;
        end
    end

    // one instruction per cycle, whenever the head is present
    assign do_retire = out_entry.valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
            head       <= '0;
        end else if (flush) begin
            // drop every parked entry, restart at slot zero
            slot_valid <= '0;
            head       <= '0;
        end else begin
            // forwarded entries never occupied the slot
            if (do_retire && !do_forward) begin
                slot_valid[head] <= 1'b0;
            end
            if (do_park) begin
                slot_valid[in_index] <= 1'b1;
            end
            // wraps at ROB_SZ
            if (do_retire) begin
                head <= head + 1'b1;
            end
        end
    end

    // payload write, no reset needed behind the valid bits
    always_ff @(posedge clock) begin
        if (do_park) begin
            slot_q[in_index] <= in_entry;
        end
    end

    // completion units must not report twice into an occupied slot
    a_no_overwrite: assert property (
        @(posedge clock) disable iff (!rst_n || flush)
        do_park |-> !slot_valid[in_index]
    ) else $error("retire_buffer: report for slot %0d while slot is still full", in_index);

    // a bypassed head must not have a stale copy sitting in its slot
    a_forward_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
        do_forward |-> !slot_valid[head]
    ) else $error("retire_buffer: forwarded head %0d already parked", head);

endmodule

//--- source/complete_stage.sv
`include "retire_settings.svh"

module complete_stage
    import retire_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  flush,
    input  complete_packet_t      co_packet,
    output retire_entry_t         in_entry,
    output logic [`ROB_IDX_W-1:0] in_index
);

    // sampled report, valid bit tracked on its own
    logic             pkt_valid_q;
    complete_packet_t pkt_q;

    // decoded pieces of the sampled report
    exception_e       err_code;
    mem_size_e        st_size;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid_q <= 1'b0;
        end else begin
            // a report arriving with the flush pulse is dropped
            pkt_valid_q <= co_packet.valid && !flush;
        end
    end

    // payload only loads on a real report
    always_ff @(posedge clock) begin
        if (co_packet.valid) begin
            pkt_q <= co_packet;
        end
    end

    // illegal wins over wfi
    always_comb begin
        if (pkt_q.illegal) begin
            err_code = ILLEGAL_INST;
        end else if (pkt_q.halt) begin
            err_code = HALTED_ON_WFI;
        end else begin
            err_code = NO_ERROR;
        end
    end

    // store width from funct3 in s format
    // sign bit of funct3 is meaningless for stores, ignored
    always_comb begin
        case (pkt_q.inst.s.funct3[1:0])
            2'b00: begin
                st_size = BYTE;
            end
            2'b01: begin
                st_size = HALF;
            end
            default: begin
                st_size = WORD;
            end
        endcase
    end

    // retire entry, straight from the register
    always_comb begin
        in_entry.valid         = pkt_valid_q;
        in_entry.inst          = pkt_q.inst;
        in_entry.function_type = pkt_q.function_type;
        // only looked at downstream when this is a store
        in_entry.mem_size      = st_size;
        in_entry.error_status  = err_code;
        in_entry.pc            = pkt_q.pc;
        in_entry.npc           = pkt_q.npc;
        in_entry.regfile_en    = pkt_q.regfile_en;
        // destination from rd in r format
        in_entry.regfile_idx   = pkt_q.inst.r.rd;
        in_entry.regfile_data  = pkt_q.regfile_data;
        in_entry.result        = pkt_q.result;
        in_entry.opb_value     = pkt_q.opb_value;
    end

    // slot the entry belongs to
    assign in_index = pkt_q.rob_index;

endmodule

//--- source/retire_pkg.sv
`include "retire_settings.svh"

package retire_pkg;

    // register format view of an instruction word
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    // store format view, rd bits become the low immediate
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } inst_s_t;

    // one 32 bit word, read either way
    typedef union packed {
        inst_r_t r;
        inst_s_t s;
    } inst_t;

    typedef enum logic [1:0] {
        ALU    = 2'h0,
        LOAD   = 2'h1,
        STORE  = 2'h2,
        BRANCH = 2'h3
    } funit_e;

    // matches the low two bits of a store funct3
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        NO_ERROR      = 2'h0,
        ILLEGAL_INST  = 2'h1,
        HALTED_ON_WFI = 2'h2
    } exception_e;

    // completion report from a functional unit
    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] rob_index;
        inst_t                 inst;
        funit_e                function_type;
        logic                  illegal;
        logic                  halt;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      npc;
        logic                  regfile_en;
        logic [`XLEN-1:0]      regfile_data;
        // address for stores
        logic [`XLEN-1:0]      result;
        // store data
        logic [`XLEN-1:0]      opb_value;
    } complete_packet_t;

    // what a reorder slot holds until its turn
    typedef struct packed {
        logic                  valid;
        inst_t                 inst;
        funit_e                function_type;
        mem_size_e             mem_size;
        exception_e            error_status;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      npc;
        logic                  regfile_en;
        logic [`REG_IDX_W-1:0] regfile_idx;
        logic [`XLEN-1:0]      regfile_data;
        logic [`XLEN-1:0]      result;
        logic [`XLEN-1:0]      opb_value;
    } retire_entry_t;

    typedef struct packed {
        logic                  valid;
        exception_e            error_status;
        logic                  wr_en;
        logic [`REG_IDX_W-1:0] wr_idx;
        logic [`XLEN-1:0]      wr_data;
        logic [`XLEN-1:0]      npc;
    } commit_t;

    typedef struct packed {
        logic             valid;
        mem_size_e        size;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } store_req_t;

endpackage

//--- source/retire_settings.svh
`ifndef RETIRE_SETTINGS_SVH
`define RETIRE_SETTINGS_SVH

// data and address width
`define XLEN 32

// reorder slots, must stay a power of two so the head wraps for free
`define ROB_SZ 16

// bits needed to name one reorder slot
`define ROB_IDX_W 4

// architectural register index
`define REG_IDX_W 5

`endif
